/* bench/ex_stimulus.txt */
# name op rs1 v1 val1 rs2 v2 val2 imm zimm pc w in1 in2 res rd rw mr mw mop bp erd edata
# every number is hex; erd 0 marks an instruction with no register write
li_x1     a 0  0 0        0  0 0        12345678 0  0    1 0 1 0 1  1 0 0 0 0 1  12345678
li_x2     0 0  0 0        0  0 0        fffffff0 0  0    1 0 1 1 2  1 0 0 0 0 2  fffffff0
add_fwd   0 1  1 0        2  1 0        0        0  0    1 0 0 0 3  1 0 0 0 0 3  12345668
sub_em    1 3  1 0        1  1 12345678 0        0  0    1 0 0 0 4  1 0 0 0 0 4  fffffff0
and_ri    2 4  1 0        0  0 0        0ff0ff00 0  0    1 0 1 0 5  1 0 0 0 0 5  0ff0ff00
or_rr     3 5  1 0        1  1 12345678 0        0  0    1 0 0 0 6  1 0 0 0 0 6  1ff4ff78
xor_mw    4 5  1 0        2  1 fffffff0 0        0  0    1 0 0 0 7  1 0 0 0 0 7  f00f00f0
sll       5 1  1 12345678 0  0 0        4        0  0    1 0 1 0 8  1 0 0 0 0 8  23456780
srl       6 2  1 fffffff0 0  0 0        4        0  0    1 0 1 0 9  1 0 0 0 0 9  0fffffff
sra       7 2  1 fffffff0 0  0 0        4        0  0    1 0 1 0 a  1 0 0 0 0 a  ffffffff
slt       8 2  1 fffffff0 1  1 12345678 0        0  0    1 0 0 0 b  1 0 0 0 0 b  1
sltu      9 2  1 fffffff0 1  1 12345678 0        0  0    1 0 0 0 c  1 0 0 0 0 c  0
zimm_add  0 0  0 0        0  0 0        100      1f 0    1 1 1 0 d  1 0 0 0 0 d  11f
link4     0 0  0 0        0  0 0        0        0  100  1 0 1 2 e  1 0 0 0 0 e  104
link2     0 0  0 0        0  0 0        0        0  200  0 0 1 2 f  1 0 0 0 0 f  202
auipc     0 0  0 0        0  0 0        20000    0  1000 1 2 1 0 10 1 0 0 0 0 10 21000
sw        0 0  1 0        7  1 f00f00f0 40       0  0    1 0 1 0 0  0 0 1 2 0 0  0
lw        0 0  1 0        0  0 0        40       0  0    1 0 1 0 11 1 1 0 2 0 11 f00f00f0
lb        0 0  1 0        0  0 0        40       0  0    1 0 1 0 12 1 1 0 0 0 12 fffffff0
use_stall 0 12 1 0        11 1 f00f00f0 0        0  0    1 0 0 0 13 1 0 0 0 0 13 f00f00e0
lbu       0 0  1 0        0  0 0        40       0  0    1 0 1 0 14 1 1 0 4 0 14 f0
lh        0 0  1 0        0  0 0        42       0  0    1 0 1 0 15 1 1 0 1 0 15 fffff00f
lhu       0 0  1 0        0  0 0        42       0  0    1 0 1 0 16 1 1 0 5 0 16 f00f
mul       b 1  1 12345678 2  1 fffffff0 0        0  0    1 0 0 0 18 1 0 0 0 0 18 dcba9880
after_mul 0 18 1 0        0  0 0        80       0  0    1 0 1 0 19 1 0 0 0 0 19 dcba9900
bp_a      0 0  0 0        0  0 0        1        5  0    1 1 1 0 1a 1 0 0 0 1 1a 6
bp_b      0 1a 1 0        0  0 0        2        0  0    1 0 1 0 1b 1 0 0 0 1 1b 8
bp_c      0 1b 1 0        1a 1 0        0        0  0    1 0 0 0 1c 1 0 0 0 1 1c e

/* tb.f */
design/ex_pkg.sv
design/ex_alu.sv
design/ex_bypass.sv
design/ex_stage.sv
design/ex_mem_stage.sv
design/ex_top.sv
bench/tb_clock.sv
bench/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(BUILD_DIR)

/* bench/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

  logic               clk;
  logic               rest;
  logic               de_valid;
  ex_pkg::de_bundle_t de;
  logic               de_ready;
  logic               wb_valid;
  ex_pkg::mw_bundle_t wb;
  logic               wb_ready = 1'b1;

  // one entry per stimulus line.
  string              stim_name[$];
  ex_pkg::de_bundle_t stim_de[$];
  logic               stim_bp[$];
  logic [4:0]         exp_rd[$];
  logic [31:0]        exp_data[$];

  int                 wb_count = 0;
  int                 pass_count = 0;
  int                 errors = 0;
  int                 limit = 0;
  int                 low_left = 0;
  logic               took = 1'b0;
  logic               started = 1'b0;
  logic               bp_on = 1'b0;
  logic [31:0]        rng = 32'd69;

  tb_clock u_clock (.clk(clk));

  ex_top u_dut (
    .clk      (clk),
    .rest     (rest),
    .de_valid (de_valid),
    .de       (de),
    .de_ready (de_ready),
    .wb_valid (wb_valid),
    .wb       (wb),
    .wb_ready (wb_ready)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $finish;
  endtask

  task automatic load_stimulus(output string err);
    int          fd;
    int          cnt;
    string       line;
    string       name;
    logic [31:0] f [22];
    err = "";
    fd = $fopen("bench/ex_stimulus.txt", "r");
    if (fd == 0) begin
      err = "could not open bench/ex_stimulus.txt";
    end else begin
      while (err == "" && !$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#") begin
          cnt = $sscanf(line,
                        "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                        f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                        f[19], f[20], f[21]);
          if (cnt != 23) begin
            err = {"malformed stimulus line: ", line};
          end else begin
            stim_name.push_back(name);
            // columns follow the field order of the decode bundle.
            stim_de.push_back(ex_pkg::de_bundle_t'({f[0][3:0], f[1][4:0], f[2][0], f[3],
                              f[4][4:0], f[5][0], f[6], f[7], f[8][4:0], f[9], f[10][0],
                              f[11][1:0], f[12][1:0], f[13][1:0], f[14][4:0], f[15][0],
                              f[16][0], f[17][0], f[18][2:0]}));
            stim_bp.push_back(f[19][0]);
            exp_rd.push_back(f[20][4:0]);
            exp_data.push_back(f[21]);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // rd 0 in the expected columns means no register write.
  task automatic check_writeback(input int idx);
    logic       exp_rw;
    logic       exp_load;
    logic       ok;
    logic [4:0] got_rd;
    exp_rw   = (exp_rd[idx] != 5'd0);
    exp_load = stim_de[idx].mem_read;
    got_rd   = wb.reg_write ? wb.rd : 5'd0;
    ok       = (wb.reg_write == exp_rw) && (got_rd == exp_rd[idx]) &&
               (wb.mem_data_valid == exp_load) &&
               (!exp_rw || (wb.reg_write_data == exp_data[idx]));
    assert (ok) else begin
      $display("ERROR %s expected rd %0d load %0d data %h, actual rd %0d load %0d data %h",
               stim_name[idx], exp_rd[idx], exp_load, exp_data[idx], got_rd,
               wb.mem_data_valid, wb.reg_write_data);
      errors++;
    end
    if (ok) begin
      pass_count++;
      $display("%s ok", stim_name[idx]);
    end
  endtask

  always @(posedge clk) begin
    took <= de_valid && de_ready;
    if (de_valid && de_ready) begin
      started <= 1'b1;
    end
  end

  // writebacks arrive in program order.
  always @(posedge clk) begin
    if (!started) begin
      assert (!wb_valid) else begin
        $display("wb_valid went high before any instruction was accepted");
        errors++;
      end
    end
    if (wb_valid && wb_ready) begin
      assert (wb_count < stim_de.size()) else begin
        $display("extra writeback seen after the last test");
        errors++;
      end
      if (wb_count < stim_de.size()) begin
        check_writeback(wb_count);
      end
      wb_count++;
    end
  end

  // random low pulses on wb_ready while a back-pressure test is presented.
  always @(negedge clk) begin
    if (low_left > 0) begin
      low_left--;
    end else if (bp_on) begin
      rng = lcg_next(rng);
      if (rng[20]) begin
        low_left = int'(rng[18:17]) + 1;
      end
    end
    wb_ready = (low_left == 0);
  end

  initial begin
    int cycles = 0;
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    abort_run("timeout: writebacks did not all arrive within the cycle limit");
  end

  initial begin
    string load_err;
    rest     = 1'b0;
    de_valid = 1'b0;
    de       = '0;
    load_stimulus(load_err);
    if (load_err != "") begin
      abort_run(load_err);
    end else begin
      limit = stim_de.size() * (ex_pkg::mul_cycles + 8) + 50;
      repeat (4) @(negedge clk);
      rest = 1'b1;
      // idle cycles with nothing accepted yet.
      repeat (3) @(negedge clk);
      for (int i = 0; i < stim_de.size(); i++) begin
        de_valid = 1'b1;
        de       = stim_de[i];
        bp_on   <= stim_bp[i];
        @(negedge clk);
        while (!took) begin
          @(negedge clk);
        end
      end
      de_valid = 1'b0;
      bp_on   <= 1'b0;
      while (wb_count < stim_de.size()) begin
        @(negedge clk);
      end
      repeat (6) @(negedge clk);
      $display("tests %0d, ok %0d, errors %0d", stim_de.size(), pass_count, errors);
      if (errors == 0 && pass_count == stim_de.size()) begin
        $display("sim passed");
      end else begin
        $display("sim failed");
      end
      $finish;
    end
  end

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // 100 ns period.
  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

endmodule

/* design/ex_top.sv */
`timescale 1ns/1ps

module ex_top (
  input  logic               clk,
  input  logic               rest,
  input  logic               de_valid,
  input  ex_pkg::de_bundle_t de,
  output logic               de_ready,
  output logic               wb_valid,
  output ex_pkg::mw_bundle_t wb,
  input  logic               wb_ready
);

  logic               em_valid;
  ex_pkg::em_bundle_t em;
  logic               em_ready;

  // the memory/writeback register doubles as the writeback port.
  ex_stage u_ex (
    .clk      (clk),
    .rest     (rest),
    .de_valid (de_valid),
    .de       (de),
    .de_ready (de_ready),
    .em_valid (em_valid),
    .em       (em),
    .em_ready (em_ready),
    .mw_valid (wb_valid),
    .mw       (wb)
  );

  ex_mem_stage u_mem (
    .clk      (clk),
    .rest     (rest),
    .em_valid (em_valid),
    .em       (em),
    .em_ready (em_ready),
    .mw_valid (wb_valid),
    .mw       (wb),
    .wb_ready (wb_ready)
  );

endmodule

/* design/ex_mem_stage.sv */
`timescale 1ns/1ps

module ex_mem_stage (
  input  logic               clk,
  input  logic               rest,
  input  logic               em_valid,
  input  ex_pkg::em_bundle_t em,
  output logic               em_ready,
  output logic               mw_valid,
  output ex_pkg::mw_bundle_t mw,
  input  logic               wb_ready
);

  logic [31:0]                       dmem [ex_pkg::dmem_words];
  logic [ex_pkg::dmem_addr_bits-1:0] word_idx;
  logic [1:0]                        byte_off;
  logic [31:0]                       rd_word;
  logic [7:0]                        rd_byte;
  logic [15:0]                       rd_half;
  logic [31:0]                       load_data;
  logic [3:0]                        wr_be;
  logic [31:0]                       wr_data;
  ex_pkg::mw_bundle_t                mw_next;

  assign em_ready = !mw_valid || wb_ready;

  assign word_idx = em.reg_data_mem_addr[ex_pkg::dmem_addr_bits+1:2];
  assign byte_off = em.reg_data_mem_addr[1:0];
  assign rd_word  = dmem[word_idx];
  assign rd_byte  = rd_word[8*byte_off +: 8];
  assign rd_half  = byte_off[1] ? rd_word[31:16] : rd_word[15:0];

  always_comb begin
    case (em.mem_op)
      ex_pkg::mem_b:  load_data = {{24{rd_byte[7]}}, rd_byte};
      ex_pkg::mem_h:  load_data = {{16{rd_half[15]}}, rd_half};
      ex_pkg::mem_bu: load_data = {24'd0, rd_byte};
      ex_pkg::mem_hu: load_data = {16'd0, rd_half};
      default:        load_data = rd_word;
    endcase
  end

  // store data is replicated across the word, the enables pick the lanes.
  always_comb begin
    case (em.mem_op)
      ex_pkg::mem_b, ex_pkg::mem_bu: begin
        wr_be   = 4'b0001 << byte_off;
        wr_data = {4{em.mem_data[7:0]}};
      end
      ex_pkg::mem_h, ex_pkg::mem_hu: begin
        wr_be   = byte_off[1] ? 4'b1100 : 4'b0011;
        wr_data = {2{em.mem_data[15:0]}};
      end
      default: begin
        wr_be   = 4'b1111;
        wr_data = em.mem_data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (em_valid && em.mem_write && em_ready) begin
      for (int i = 0; i < 4; i++) begin
        if (wr_be[i]) begin
          dmem[word_idx][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

  always_comb begin
    mw_next.rd             = em.rd;
    mw_next.reg_write      = em.reg_write;
    mw_next.reg_write_data = em.mem_read ? load_data : em.reg_data_mem_addr;
    mw_next.mem_data_valid = em.mem_read;
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      mw_valid <= 1'b0;
    end else if (em_ready) begin
      mw_valid <= em_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (em_ready) begin
      mw <= mw_next;
    end
  end

endmodule

/* design/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
  input  logic               clk,
  input  logic               rest,
  input  logic               de_valid,
  input  ex_pkg::de_bundle_t de,
  output logic               de_ready,
  output logic               em_valid,
  output ex_pkg::em_bundle_t em,
  input  logic               em_ready,
  input  logic               mw_valid,
  input  ex_pkg::mw_bundle_t mw
);

  ex_pkg::fwd_sel_e   rs1_sel;
  ex_pkg::fwd_sel_e   rs2_sel;
  logic               stall;
  logic [31:0]        rs1_value;
  logic [31:0]        rs2_value;
  logic [31:0]        alu_in1;
  logic [31:0]        alu_in2;
  logic [31:0]        alu_out;
  logic               alu_ready;
  logic               alu_start;
  logic [31:0]        link_addr;
  logic [31:0]        result;
  logic               em_adv;
  logic               accept;
  ex_pkg::em_bundle_t em_next;

  // the register can take a new item when empty or draining.
  assign em_adv    = !em_valid || em_ready;
  assign alu_start = de_valid && !stall && em_adv;
  assign de_ready  = alu_ready && !stall && em_adv;
  assign accept    = de_valid && de_ready;

  assign link_addr = de.pc + (de.istr_width ? 32'd4 : 32'd2);

  always_comb begin
    case (rs1_sel)
      ex_pkg::fwd_em: rs1_value = em.reg_data_mem_addr;
      ex_pkg::fwd_mw: rs1_value = mw.reg_write_data;
      default:        rs1_value = de.rs1_value;
    endcase
    case (rs2_sel)
      ex_pkg::fwd_em: rs2_value = em.reg_data_mem_addr;
      ex_pkg::fwd_mw: rs2_value = mw.reg_write_data;
      default:        rs2_value = de.rs2_value;
    endcase
  end

  always_comb begin
    case (de.in1_sel)
      ex_pkg::in1_zimm: alu_in1 = {27'd0, de.zimm};
      ex_pkg::in1_pc:   alu_in1 = de.pc;
      default:          alu_in1 = rs1_value;
    endcase
    case (de.in2_sel)
      ex_pkg::in2_imm: alu_in2 = de.imm;
      default:         alu_in2 = rs2_value;
    endcase
    case (de.res_sel)
      ex_pkg::res_imm:  result = de.imm;
      ex_pkg::res_link: result = link_addr;
      default:          result = alu_out;
    endcase
  end

  always_comb begin
    em_next.reg_data_mem_addr = result;
    em_next.mem_data          = rs2_value;
    em_next.mem_read          = de.mem_read;
    em_next.mem_write         = de.mem_write;
    em_next.mem_op            = de.mem_op;
    em_next.rd                = de.rd;
    em_next.reg_write         = de.reg_write;
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      em_valid <= 1'b0;
    end else if (em_adv) begin
      em_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (em_adv) begin
      em <= em_next;
    end
  end

  ex_alu u_alu (
    .clk   (clk),
    .rest  (rest),
    .op    (de.alu_op),
    .start (alu_start),
    .in1   (alu_in1),
    .in2   (alu_in2),
    .ready (alu_ready),
    .out   (alu_out)
  );

  ex_bypass u_bypass (
    .de_valid (de_valid),
    .de       (de),
    .em_valid (em_valid),
    .em       (em),
    .mw_valid (mw_valid),
    .mw       (mw),
    .rs1_sel  (rs1_sel),
    .rs2_sel  (rs2_sel),
    .stall    (stall)
  );

endmodule

/* design/ex_bypass.sv */
`timescale 1ns/1ps

module ex_bypass (
  input  logic               de_valid,
  input  ex_pkg::de_bundle_t de,
  input  logic               em_valid,
  input  ex_pkg::em_bundle_t em,
  input  logic               mw_valid,
  input  ex_pkg::mw_bundle_t mw,
  output ex_pkg::fwd_sel_e   rs1_sel,
  output ex_pkg::fwd_sel_e   rs2_sel,
  output logic               stall
);

  // newest writer wins, x0 never forwards.
  function automatic ex_pkg::fwd_sel_e pick_src(input logic [4:0] rs, input logic rs_valid);
    pick_src = ex_pkg::fwd_de;
    if (rs_valid && (rs != 5'd0)) begin
      if (em_valid && em.reg_write && (em.rd == rs)) begin
        pick_src = ex_pkg::fwd_em;
      end else if (mw_valid && mw.reg_write && (mw.rd == rs)) begin
        pick_src = ex_pkg::fwd_mw;
      end
    end
  endfunction

  // em holds only the address of a load, so its data is not ready yet.
  function automatic logic load_hit(input logic [4:0] rs, input logic rs_valid);
    load_hit = rs_valid && (rs != 5'd0) && em_valid && em.reg_write &&
               em.mem_read && (em.rd == rs);
  endfunction

  always_comb begin
    rs1_sel = pick_src(de.rs1, de.rs1_valid);
    rs2_sel = pick_src(de.rs2, de.rs2_valid);
    stall   = de_valid && (load_hit(de.rs1, de.rs1_valid) || load_hit(de.rs2, de.rs2_valid));
  end

endmodule

/* design/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
  input  logic            clk,
  input  logic            rest,
  input  ex_pkg::alu_op_e op,
  input  logic            start,
  input  logic [31:0]     in1,
  input  logic [31:0]     in2,
  output logic            ready,
  output logic [31:0]     out
);

  ex_pkg::mul_state_e              state;
  logic [ex_pkg::mul_cnt_bits-1:0] count;
  logic [31:0]                     acc;
  logic [31:0]                     mcand;
  logic [31:0]                     mplier;
  logic                            mul_go;

  // a new multiply begins only from idle.
  assign mul_go = start && (op == ex_pkg::alu_mul) && (state == ex_pkg::mul_idle);

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      state <= ex_pkg::mul_idle;
      count <= '0;
    end else begin
      case (state)
        ex_pkg::mul_idle: begin
          if (mul_go) begin
            state <= ex_pkg::mul_run;
            count <= '0;
          end
        end
        ex_pkg::mul_run: begin
          count <= count + 1'b1;
          if (count == ex_pkg::mul_last_run) begin
            state <= ex_pkg::mul_done;
          end
        end
        ex_pkg::mul_done: begin
          // product stays on out until the stage takes it.
          if (start) begin
            state <= ex_pkg::mul_idle;
          end
        end
        default: state <= ex_pkg::mul_idle;
      endcase
    end
  end

  // shift-add datapath, one multiplier bit per cycle.
  always_ff @(posedge clk) begin
    if (mul_go) begin
      acc    <= in2[0] ? in1 : 32'd0;
      mcand  <= in1 << 1;
      mplier <= in2 >> 1;
    end else if (state == ex_pkg::mul_run) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  always_comb begin
    case (op)
      ex_pkg::alu_add:    out = in1 + in2;
      ex_pkg::alu_sub:    out = in1 - in2;
      ex_pkg::alu_and:    out = in1 & in2;
      ex_pkg::alu_or:     out = in1 | in2;
      ex_pkg::alu_xor:    out = in1 ^ in2;
      ex_pkg::alu_sll:    out = in1 << in2[4:0];
      ex_pkg::alu_srl:    out = in1 >> in2[4:0];
      ex_pkg::alu_sra:    out = $signed(in1) >>> in2[4:0];
      ex_pkg::alu_slt:    out = {31'd0, $signed(in1) < $signed(in2)};
      ex_pkg::alu_sltu:   out = {31'd0, in1 < in2};
      ex_pkg::alu_pass_b: out = in2;
      ex_pkg::alu_mul:    out = acc;
      default:            out = 32'd0;
    endcase
  end

  assign ready = (op != ex_pkg::alu_mul) || (state == ex_pkg::mul_done);

endmodule

/* design/ex_pkg.sv */
package ex_pkg;

  // data memory geometry.
  localparam int dmem_words     = 64;
  localparam int dmem_addr_bits = 6;

  // iterative multiplier timing.
  localparam int mul_cycles   = 32;
  localparam int mul_cnt_bits = $clog2(mul_cycles);
  // the first step is done in the cycle the multiply is presented.
  localparam logic [mul_cnt_bits-1:0] mul_last_run = mul_cnt_bits'(mul_cycles - 2);

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_srl, alu_sra,
    alu_slt, alu_sltu, alu_pass_b, alu_mul
  } alu_op_e;

  typedef enum logic [1:0] {in1_rs1, in1_zimm, in1_pc} in1_sel_e;

  typedef enum logic [1:0] {in2_rs2, in2_imm} in2_sel_e;

  // res_link is pc plus the instruction width.
  typedef enum logic [1:0] {res_alu, res_imm, res_link} res_sel_e;

  typedef enum logic [1:0] {fwd_de, fwd_em, fwd_mw} fwd_sel_e;

  // same encoding as the funct3 field of rv32 loads and stores.
  typedef enum logic [2:0] {
    mem_b  = 3'd0,
    mem_h  = 3'd1,
    mem_w  = 3'd2,
    mem_bu = 3'd4,
    mem_hu = 3'd5
  } mem_op_e;

  typedef enum logic [1:0] {mul_idle, mul_run, mul_done} mul_state_e;

  typedef struct packed {
    alu_op_e     alu_op;
    logic [4:0]  rs1;
    logic        rs1_valid;
    logic [31:0] rs1_value;
    logic [4:0]  rs2;
    logic        rs2_valid;
    logic [31:0] rs2_value;
    logic [31:0] imm;
    logic [4:0]  zimm;
    logic [31:0] pc;
    logic        istr_width;  // 1 for a 32-bit instruction, 0 for compressed.
    in1_sel_e    in1_sel;
    in2_sel_e    in2_sel;
    res_sel_e    res_sel;
    logic [4:0]  rd;
    logic        reg_write;
    logic        mem_read;
    logic        mem_write;
    mem_op_e     mem_op;
  } de_bundle_t;

  typedef struct packed {
    logic [31:0] reg_data_mem_addr;
    logic [31:0] mem_data;
    logic        mem_read;
    logic        mem_write;
    mem_op_e     mem_op;
    logic [4:0]  rd;
    logic        reg_write;
  } em_bundle_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic        reg_write;
    logic [31:0] reg_write_data;
    logic        mem_data_valid;
  } mw_bundle_t;

endpackage
